//--- files.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/bus_sequencer.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/cpu_top.sv
verif/cpu_asserts.sv
verif/cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module cpu_tb -o cpu_sim

status=0
./obj_dir/cpu_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failures found" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation passed"

//--- verif/cpu_tb.sv
`default_nettype none
`include "cpu_config.svh"

module cpu_tb;
	localparam logic [15:0] prog_base   = 16'h0000;
	localparam logic [15:0] far_adr     = 16'h8000;  // JP target
	localparam logic [7:0]  result_page = 8'hc0;     // H for every store
	localparam logic [7:0]  skip_mark   = 8'hdd;     // In D, stored only on fall-through
	localparam logic [7:0]  taken_mark  = 8'hee;     // In E, stored at each branch target

	logic        clk;
	logic        reset;
	logic [15:0] adr;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic        read;
	logic        write;
	logic [7:0]  mem [65536];

	integer      seed = 32'hbace_8279;
	logic [7:0]  r [8];                  // Model registers in opcode field order
	logic        fz;
	logic        fc;
	logic [15:0] pc_b;                   // Build address
	int          cycles;                 // Machine cycles the program should take
	logic [7:0]  stored [logic [15:0]];  // Bytes the program has written so far
	logic [15:0] exp_adr [$];
	logic [7:0]  exp_dat [$];
	int          errors = 0;
	int          checked = 0;
	bit          built = 1'b0;
	bit          all_seen = 1'b0;
	bit          first_read = 1'b0;
	logic        read_q = 1'b0;
	logic        write_q = 1'b0;

	cpu_top i_dut (.*);

	always #20 clk = ~clk;

	assign din = mem[adr];  // Combinational read
	always @(posedge clk)
		if (write)
			mem[adr] <= dout;

	function automatic logic [7:0] fill(input logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'h5a;
	endfunction

	function automatic logic [7:0] rnd();
		return 8'($random(seed));
	endfunction

	function automatic logic [7:0] mem_at_hl();
		logic [15:0] hl;
		hl = {r[4], r[5]};
		return stored.exists(hl) ? stored[hl] : fill(hl);
	endfunction

	task automatic put(input logic [7:0] b);
		mem[pc_b] = b;
		pc_b = pc_b + 16'd1;
	endtask

	task automatic record(input int s);
		exp_adr.push_back({r[4], r[5]});
		exp_dat.push_back(r[s]);
		stored[{r[4], r[5]}] = r[s];
	endtask

	task automatic ld_imm(input int d, input logic [7:0] v);
		put(8'(d * 8 + 6));
		put(v);
		r[d] = v;
		cycles += 2;
	endtask

	task automatic mov(input int d, input int s);
		put(8'(8'h40 + d * 8 + s));
		r[d] = r[s];
		cycles += 1;
	endtask

	task automatic st(input int s);
		put(8'(8'h70 + s));  // LD (HL),r
		record(s);
		cycles += 2;
	endtask

	task automatic ld_hl(input int d);
		put(8'(8'h46 + d * 8));
		r[d] = mem_at_hl();
		cycles += 2;
	endtask

	// Accumulator op per the flag rules, CP keeps A
	task automatic exec_alu(input int op, input logic [7:0] b);
		int a;
		int x;
		int cin;
		a = int'(r[7]);
		cin = (op == 1 || op == 3) ? int'(fc) : 0;
		case (op)
		0, 1:    x = a + int'(b) + cin;
		2, 3, 7: x = a - int'(b) - cin;
		4:       x = a & int'(b);
		5:       x = a ^ int'(b);
		default: x = a | int'(b);
		endcase
		fz = ((x & 255) == 0);
		fc = (x > 255) || (x < 0);  // Carry out or borrow
		if (op != 7)
			r[7] = 8'(x);
	endtask

	task automatic alu_imm(input int op, input logic [7:0] v);
		put(8'(8'hc6 + op * 8));
		put(v);
		exec_alu(op, v);
		cycles += 2;
	endtask

	task automatic alu_reg(input int op, input int s);
		put(8'(8'h80 + op * 8 + s));
		exec_alu(op, r[s]);
		cycles += 1;
	endtask

	task automatic alu_mem(input int op);
		put(8'(8'h86 + op * 8));
		exec_alu(op, mem_at_hl());
		cycles += 2;
	endtask

	// INC or DEC, C untouched
	task automatic incdec(input int d, input bit dec);
		put(8'(8'h04 + d * 8 + dec));
		r[d] = dec ? r[d] - 8'd1 : r[d] + 8'd1;
		fz = (r[d] == 8'h00);
		cycles += 1;
	endtask

	// JR cc,+1 over a store of D, then a store of E at the target
	task automatic branch(input logic [7:0] opc);
		logic take;
		case (opc)
		8'h20:   take = !fz;
		8'h28:   take = fz;
		8'h30:   take = !fc;
		8'h38:   take = fc;
		default: take = 1'b1;
		endcase
		put(opc);
		put(8'h01);
		put(8'h72);
		if (take)
			cycles += 3;
		else
		begin
			record(2);
			cycles += 4;
		end
		st(3);
	endtask

	task automatic jp(input logic [15:0] a);
		put(8'hc3);
		put(a[7:0]);
		put(a[15:8]);
		pc_b = a;
		cycles += 4;
	endtask

	task automatic build_program();
		pc_b = prog_base;
		cycles = 0;
		fz = 1'b0;
		fc = 1'b0;
		for (int i = 0; i < 8; i++)
			r[i] = 8'h00;
		put(8'h00);  // NOP
		cycles += 1;
		for (int d = 0; d < 8; d++)
			if (d == 4)
				ld_imm(d, result_page);
			else if (d == 5)
				ld_imm(d, rnd() & 8'h7f);  // Keeps clear of the halt marker
			else if (d != 6)
				ld_imm(d, rnd());
		for (int d = 0; d < 8; d++)
			if (d != 6)
				st(d);
		for (int op = 0; op < 8; op++)
		begin
			ld_imm(7, rnd());
			alu_imm(op, rnd());
			st(7);
			ld_hl(0);  // B gets the byte just stored
			ld_imm(7, rnd());
			alu_reg(op, 0);
			st(7);
			alu_mem(op);
			st(7);
		end
		ld_imm(2, skip_mark);
		ld_imm(3, taken_mark);
		ld_imm(5, 8'h80);
		ld_imm(0, 8'hff);
		incdec(0, 1'b0);  // Wraps to 0
		branch(8'h28);
		branch(8'h20);
		incdec(0, 1'b1);  // Back to ff
		branch(8'h20);
		branch(8'h28);
		ld_imm(1, 8'h01);
		incdec(1, 1'b1);
		branch(8'h28);
		ld_imm(7, 8'h10);
		alu_imm(2, 8'h20);  // Borrow sets C
		branch(8'h38);
		branch(8'h30);
		alu_imm(0, 8'h01);
		branch(8'h30);
		branch(8'h18);
		jp(far_adr);
		ld_imm(5, 8'h90);
		st(7);
		ld_imm(5, 8'hff);  // Halt marker at c0ff
		mov(0, 3);
		st(0);
		put(8'h76);
		cycles += 1;
	endtask

	task automatic check_write();
		logic [15:0] ea;
		logic [7:0]  ed;
		assert (first_read)
			else begin errors++; $display("A write came before the first opcode fetch"); end
		if (exp_adr.size() == 0)
		begin
			errors++;
			$display("Extra write of %h to %h at time %0t, none was due", dout, adr, $time);
		end
		else
		begin
			ea = exp_adr.pop_front();
			ed = exp_dat.pop_front();
			checked++;
			assert (adr == ea && dout == ed)
				else begin
					errors++;
					$display("** Error @ %0t: write %h to %h, expected %h to %h",
						$time, dout, adr, ed, ea);
				end
			if (exp_adr.size() == 0)
				all_seen = 1'b1;
		end
	endtask

	task automatic finish_run();
		errors += i_dut.i_asserts.fail_count;
		$display("Writes checked: %0d, errors: %0d", checked, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	// Strobes settle after the rising edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (read && !read_q && !first_read)
			begin
				first_read = 1'b1;
				assert (adr == `CPU_RESET_PC)
					else begin errors++; $display("** Error @ %0t: first fetch at %h", $time, adr); end
			end
			if (write && !write_q)
				check_write();
		end
		read_q = read;
		write_q = write;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		for (int i = 0; i < 65536; i++)
			mem[i] = fill(16'(i));
		build_program();
		built = 1'b1;
		repeat (4) @(posedge clk);
		#2 reset = 1'b0;
		wait (all_seen);
		repeat (40 * `CPU_MCYCLE_CLOCKS) @(posedge clk);  // Quiet window after HALT
		finish_run();
	end

	// Watchdog, program length plus 50 machine cycles
	initial
	begin
		wait (built);
		#(longint'(cycles + 50) * 40 * `CPU_MCYCLE_CLOCKS);
		$display("Timeout with %0d expected writes still missing", exp_adr.size());
		errors++;
		finish_run();
	end

endmodule

`default_nettype wire

//--- verif/cpu_asserts.sv
`default_nettype none
`include "cpu_config.svh"

module cpu_asserts #(
	parameter logic [`CPU_ADR_W-1:0] halt_adr = 16'hc0ff  // Address of the last store before HALT
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`CPU_ADR_W-1:0] adr,
	input  logic                  read,
	input  logic                  write
);
	logic marker_seen;     // Halt marker write has started
	logic marker_done;     // And has ended
	logic read_q;
	int   reads_after;     // Read cycles since the marker
	int   fail_count = 0;  // Summed into the closing line by the testbench

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			marker_seen <= 1'b0;
			marker_done <= 1'b0;
			read_q      <= 1'b0;
			reads_after <= 0;
		end
		else
		begin
			read_q <= read;
			if (write && adr == halt_adr)
				marker_seen <= 1'b1;
			if (marker_seen && !write)
				marker_done <= 1'b1;
			if (marker_seen && read && !read_q)
				reads_after <= reads_after + 1;  // Only the HALT fetch may follow
		end
	end

	a_no_overlap: assert property (@(posedge clk) !(read && write))
		else begin fail_count++; $error("read and write high together"); end

	// Sync reset, so the bus is quiet from the edge after reset is seen
	a_quiet_in_reset: assert property (@(posedge clk) $past(reset) |-> !read && !write)
		else begin fail_count++; $error("bus strobe during reset"); end

	a_adr_stable: assert property (@(posedge clk) disable iff (reset)
		(read || write) && $past(read || write) |-> $stable(adr))
		else begin fail_count++; $error("adr moved during a strobe"); end

	a_halt_no_write: assert property (@(posedge clk) disable iff (reset) marker_done |-> !write)
		else begin fail_count++; $error("write after the halt marker"); end

	a_halt_one_fetch: assert property (@(posedge clk) disable iff (reset)
		marker_seen |-> reads_after <= 1)
		else begin fail_count++; $error("reads go on after HALT"); end

endmodule

bind cpu_top cpu_asserts #(.halt_adr(16'hc0ff)) i_asserts (
	.clk   (clk),
	.reset (reset),
	.adr   (adr),
	.read  (read),
	.write (write)
);

`default_nettype wire

//--- verilog/cpu_top.sv
`default_nettype none
`include "cpu_config.svh"

module cpu_top (
	input  logic                   clk,
	input  logic                   reset,
	output logic [`CPU_ADR_W-1:0]  adr,
	input  logic [`CPU_DATA_W-1:0] din,
	output logic [`CPU_DATA_W-1:0] dout,
	output logic                   read,
	output logic                   write
);
	// Sequencer side
	cpu_pkg::bus_op_t              bus_op;
	logic [`CPU_ADR_W-1:0]         bus_adr;
	logic [`CPU_DATA_W-1:0]        bus_wdata;
	logic                          mcycle_end;
	logic [`CPU_DATA_W-1:0]        rdata;
	// Register file side
	cpu_pkg::reg_sel_t             src_sel;
	cpu_pkg::reg_sel_t             dst_sel;
	logic [`CPU_DATA_W-1:0]        src_data;
	logic [`CPU_DATA_W-1:0]        dst_data;
	logic [`CPU_DATA_W-1:0]        acc;
	logic [`CPU_ADR_W-1:0]         hl;
	logic [`CPU_FLAG_Z:`CPU_FLAG_C] flags;
	logic                          wr_en;
	logic [`CPU_DATA_W-1:0]        wr_data;
	logic                          flags_en;
	logic [`CPU_FLAG_Z:`CPU_FLAG_C] flags_in;
	// ALU side
	cpu_pkg::alu_op_t              alu_op;
	logic [`CPU_DATA_W-1:0]        alu_b;
	logic [`CPU_DATA_W-1:0]        result;
	logic [`CPU_FLAG_Z:`CPU_FLAG_C] flags_out;

	bus_sequencer i_seq (
		.clk        (clk),
		.reset      (reset),
		.bus_op     (bus_op),
		.bus_adr    (bus_adr),
		.bus_wdata  (bus_wdata),
		.din        (din),
		.adr        (adr),
		.dout       (dout),
		.read       (read),
		.write      (write),
		.phase      (),  // Control unit steps on mcycle_end alone
		.mcycle_end (mcycle_end),
		.rdata      (rdata)
	);

	// Port names match the nets above
	control_unit i_ctrl (.*);

	register_file i_regs (.*);

	// A is always the left operand
	alu i_alu (
		.op        (alu_op),
		.a         (acc),
		.b         (alu_b),
		.carry_in  (flags[`CPU_FLAG_C]),  // ADC, SBC, and kept C for INC/DEC
		.result    (result),
		.flags_out (flags_out)
	);

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`default_nettype none
`include "cpu_config.svh"

module register_file (
	input  logic                           clk,
	input  logic                           reset,
	input  cpu_pkg::reg_sel_t              src_sel,
	input  cpu_pkg::reg_sel_t              dst_sel,
	input  logic                           wr_en,
	input  logic [`CPU_DATA_W-1:0]         wr_data,
	input  logic                           flags_en,
	input  logic [`CPU_FLAG_Z:`CPU_FLAG_C] flags_in,
	output logic [`CPU_DATA_W-1:0]         src_data,
	output logic [`CPU_DATA_W-1:0]         dst_data,
	output logic [`CPU_DATA_W-1:0]         acc,
	output logic [`CPU_ADR_W-1:0]          hl,
	output logic [`CPU_FLAG_Z:`CPU_FLAG_C] flags
);
	logic [`CPU_DATA_W-1:0] regs [7];  // B C D E H L A

	// Selector to array slot, A moves down into the HL hole
	function automatic logic [2:0] slot(input cpu_pkg::reg_sel_t sel);
		slot = (sel == cpu_pkg::reg_a) ? 3'd6 : 3'(sel);
	endfunction

	// (HL) reads as zero here, its data comes over the bus
	assign src_data = (src_sel == cpu_pkg::reg_hl_mem) ? '0 : regs[slot(src_sel)];
	assign dst_data = (dst_sel == cpu_pkg::reg_hl_mem) ? '0 : regs[slot(dst_sel)];

	assign acc = regs[6];
	assign hl  = {regs[4], regs[5]};  // H high, L low

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 7; i++)
				regs[i] <= '0;
			flags <= '0;
		end
		else
		begin
			if (wr_en && dst_sel != cpu_pkg::reg_hl_mem)
				regs[slot(dst_sel)] <= wr_data;
			if (flags_en)
				flags <= flags_in;  // All four at once
		end
	end

endmodule

`default_nettype wire

//--- verilog/control_unit.sv
`default_nettype none
`include "cpu_config.svh"

module control_unit (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           mcycle_end,
	input  logic [`CPU_DATA_W-1:0]         rdata,
	output cpu_pkg::bus_op_t               bus_op,
	output logic [`CPU_ADR_W-1:0]          bus_adr,
	output logic [`CPU_DATA_W-1:0]         bus_wdata,
	output cpu_pkg::reg_sel_t              src_sel,
	output cpu_pkg::reg_sel_t              dst_sel,
	input  logic [`CPU_DATA_W-1:0]         src_data,
	input  logic [`CPU_DATA_W-1:0]         dst_data,
	input  logic [`CPU_ADR_W-1:0]          hl,
	input  logic [`CPU_FLAG_Z:`CPU_FLAG_C] flags,
	output cpu_pkg::alu_op_t               alu_op,
	output logic [`CPU_DATA_W-1:0]         alu_b,
	input  logic [`CPU_DATA_W-1:0]         result,
	input  logic [`CPU_FLAG_Z:`CPU_FLAG_C] flags_out,
	output logic                           wr_en,
	output logic [`CPU_DATA_W-1:0]         wr_data,
	output logic                           flags_en,
	output logic [`CPU_FLAG_Z:`CPU_FLAG_C] flags_in
);
	cpu_pkg::mcycle_t       mcycle;
	cpu_pkg::mcycle_t       mc_next;
	logic [`CPU_ADR_W-1:0]  pc;
	logic [`CPU_DATA_W-1:0] opcode;  // Held for the later cycles
	logic [`CPU_DATA_W-1:0] imm_lo;
	logic [`CPU_DATA_W-1:0] imm_hi;
	logic [`CPU_DATA_W-1:0] op;      // Opcode being decoded
	logic                   is_ld;
	logic                   is_ld_imm;
	logic                   is_alu_reg;
	logic                   is_alu_imm;
	logic                   is_incdec;
	logic                   is_jp;
	logic                   is_jr;
	logic                   is_halt;
	logic                   jr_take;
	logic                   exec;    // Last cycle of an instruction that may write back

	// During fetch the opcode is still on rdata
	assign op = (mcycle == cpu_pkg::mc_fetch) ? rdata : opcode;

	// Anything outside these groups runs as NOP
	assign is_halt    = (op == 8'h76);
	assign is_ld      = (op[7:6] == 2'b01) && !is_halt;
	assign is_ld_imm  = (op[7:6] == 2'b00) && (op[2:0] == 3'd6) && (op[5:3] != 3'd6);
	assign is_alu_reg = (op[7:6] == 2'b10);
	assign is_alu_imm = (op[7:6] == 2'b11) && (op[2:0] == 3'd6);
	assign is_incdec  = (op[7:6] == 2'b00) && (op[2:1] == 2'b10) && (op[5:3] != 3'd6);
	assign is_jp      = (op == 8'hc3);
	assign is_jr      = (op == 8'h18) || ((op[7:5] == 3'b001) && (op[2:0] == 3'b000));

	// Bit 4 picks C or Z, bit 3 the wanted level
	assign jr_take = (op == 8'h18) || (flags[op[4] ? `CPU_FLAG_C : `CPU_FLAG_Z] == op[3]);

	assign src_sel = cpu_pkg::reg_sel_t'(op[2:0]);
	assign dst_sel = (is_alu_reg || is_alu_imm) ? cpu_pkg::reg_a : cpu_pkg::reg_sel_t'(op[5:3]);

	// Operand from a register in fetch, else from the bus byte
	assign alu_b = (mcycle != cpu_pkg::mc_fetch) ? rdata :
		(is_incdec ? dst_data : src_data);
	assign alu_op = is_incdec ? (op[0] ? cpu_pkg::alu_dec : cpu_pkg::alu_inc) :
		(is_alu_reg || is_alu_imm) ? cpu_pkg::alu_op_t'({1'b0, op[5:3]}) : cpu_pkg::alu_pass;

	// CP updates flags only
	assign wr_en    = mcycle_end && exec && (is_ld || is_ld_imm || is_incdec ||
		((is_alu_reg || is_alu_imm) && op[5:3] != 3'd7));
	assign flags_en = mcycle_end && exec && (is_alu_reg || is_alu_imm || is_incdec);
	assign wr_data  = result;
	assign flags_in = flags_out;

	assign bus_wdata = src_data;  // Only LD (HL),r stores

	always_comb
	begin
		bus_op  = cpu_pkg::bus_idle;
		bus_adr = pc;
		case (mcycle)
		cpu_pkg::mc_fetch,
		cpu_pkg::mc_imm_lo,
		cpu_pkg::mc_imm_hi:
			bus_op = cpu_pkg::bus_read;  // Stream bytes at PC
		cpu_pkg::mc_mem_rd:
		begin
			bus_op  = cpu_pkg::bus_read;
			bus_adr = hl;
		end
		cpu_pkg::mc_mem_wr:
		begin
			bus_op  = cpu_pkg::bus_write;
			bus_adr = hl;
		end
		default:
			bus_op = cpu_pkg::bus_idle;  // Jump and halt keep the bus quiet
		endcase
	end

	// Next machine cycle
	always_comb
	begin
		mc_next = cpu_pkg::mc_fetch;
		exec    = 1'b0;
		case (mcycle)
		cpu_pkg::mc_fetch:
			if (is_halt)
				mc_next = cpu_pkg::mc_halted;
			else if (is_ld_imm || is_alu_imm || is_jp || is_jr)
				mc_next = cpu_pkg::mc_imm_lo;
			else if ((is_ld || is_alu_reg) && op[2:0] == 3'd6)
				mc_next = cpu_pkg::mc_mem_rd;
			else if (is_ld && op[5:3] == 3'd6)
				mc_next = cpu_pkg::mc_mem_wr;
			else
				exec = 1'b1;  // Single-cycle ops
		cpu_pkg::mc_imm_lo:
			if (is_jp)
				mc_next = cpu_pkg::mc_imm_hi;
			else if (is_jr)
				mc_next = jr_take ? cpu_pkg::mc_jump : cpu_pkg::mc_fetch;
			else
				exec = 1'b1;
		cpu_pkg::mc_imm_hi:
			mc_next = cpu_pkg::mc_jump;
		cpu_pkg::mc_mem_rd:
			exec = 1'b1;
		cpu_pkg::mc_halted:
			mc_next = cpu_pkg::mc_halted;  // Left only through reset
		default:
			exec = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			mcycle <= cpu_pkg::mc_fetch;
			pc     <= `CPU_RESET_PC;
		end
		else if (mcycle_end)
		begin
			mcycle <= mc_next;
			case (mcycle)
			cpu_pkg::mc_fetch,
			cpu_pkg::mc_imm_lo,
			cpu_pkg::mc_imm_hi:
				pc <= pc + 16'd1;  // Past each fetched byte
			cpu_pkg::mc_jump:
				// JR offset is relative to the next instruction
				pc <= is_jp ? {imm_hi, imm_lo} : pc + {{8{imm_lo[7]}}, imm_lo};
			default:
				pc <= pc;
			endcase
		end
	end

	// Fetched bytes
	always_ff @(posedge clk)
	begin
		if (mcycle_end)
		begin
			case (mcycle)
			cpu_pkg::mc_fetch:  opcode <= rdata;
			cpu_pkg::mc_imm_lo: imm_lo <= rdata;
			cpu_pkg::mc_imm_hi: imm_hi <= rdata;
			default:            opcode <= opcode;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/bus_sequencer.sv
`default_nettype none
`include "cpu_config.svh"

module bus_sequencer (
	input  logic                   clk,
	input  logic                   reset,
	input  cpu_pkg::bus_op_t       bus_op,
	input  logic [`CPU_ADR_W-1:0]  bus_adr,
	input  logic [`CPU_DATA_W-1:0] bus_wdata,
	input  logic [`CPU_DATA_W-1:0] din,
	output logic [`CPU_ADR_W-1:0]  adr,
	output logic [`CPU_DATA_W-1:0] dout,
	output logic                   read,
	output logic                   write,
	output logic [1:0]             phase,
	output logic                   mcycle_end,
	output logic [`CPU_DATA_W-1:0] rdata
);
	cpu_pkg::bus_op_t req;     // Request held for the rest of the cycle
	logic             strobe;  // Phases 1 and 2

	// Last clock of the machine cycle
	assign mcycle_end = (phase == 2'(`CPU_MCYCLE_CLOCKS - 1));
	assign strobe     = (phase == 2'd1) || (phase == 2'd2);

	// Strobes never overlap since req holds one kind only
	assign read  = strobe && (req == cpu_pkg::bus_read);
	assign write = strobe && (req == cpu_pkg::bus_write);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= 2'd0;
			req   <= cpu_pkg::bus_idle;
		end
		else
		begin
			phase <= mcycle_end ? 2'd0 : phase + 2'd1;  // Keeps running when idle
			if (phase == 2'd0)
				req <= bus_op;  // Control unit request sampled here
		end
	end

	// Address and write data stay put from phase 1 to cycle end
	always_ff @(posedge clk)
	begin
		if (phase == 2'd0)
		begin
			adr  <= bus_adr;
			dout <= bus_wdata;
		end
		if (phase == 2'd2 && req == cpu_pkg::bus_read)
			rdata <= din;  // Valid from phase 3 on
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none
`include "cpu_config.svh"

module alu (
	input  cpu_pkg::alu_op_t               op,
	input  logic [`CPU_DATA_W-1:0]         a,
	input  logic [`CPU_DATA_W-1:0]         b,
	input  logic                           carry_in,
	output logic [`CPU_DATA_W-1:0]         result,
	output logic [`CPU_FLAG_Z:`CPU_FLAG_C] flags_out
);
	logic [`CPU_DATA_W:0] wide;  // Bit 8 is carry or borrow out of bit 7
	logic [4:0]           low;   // Bit 4 is carry or borrow out of bit 3
	logic                 cin;

	// Old carry only enters ADC and SBC
	assign cin = carry_in && (op == cpu_pkg::alu_adc || op == cpu_pkg::alu_sbc);

	always_comb
	begin
		wide = '0;
		low  = '0;
		case (op)
		cpu_pkg::alu_add,
		cpu_pkg::alu_adc:
		begin
			wide = {1'b0, a} + {1'b0, b} + {8'd0, cin};
			low  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
		end
		cpu_pkg::alu_sub,
		cpu_pkg::alu_sbc,
		cpu_pkg::alu_cp:
		begin
			wide = {1'b0, a} - {1'b0, b} - {8'd0, cin};
			low  = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
		end
		cpu_pkg::alu_and:
		begin
			wide = {1'b0, a & b};
			low  = 5'h10;  // H always set
		end
		cpu_pkg::alu_xor: wide = {1'b0, a ^ b};
		cpu_pkg::alu_or:  wide = {1'b0, a | b};
		cpu_pkg::alu_inc:
		begin
			wide = {1'b0, b} + 9'd1;
			low  = {1'b0, b[3:0]} + 5'd1;
		end
		cpu_pkg::alu_dec:
		begin
			wide = {1'b0, b} - 9'd1;
			low  = {1'b0, b[3:0]} - 5'd1;
		end
		default:
			wide = {1'b0, b};  // Pass for loads
		endcase
	end

	assign result = wide[`CPU_DATA_W-1:0];

	assign flags_out[`CPU_FLAG_Z] = (result == '0);
	assign flags_out[`CPU_FLAG_N] = op inside {cpu_pkg::alu_sub, cpu_pkg::alu_sbc,
		cpu_pkg::alu_cp, cpu_pkg::alu_dec};
	assign flags_out[`CPU_FLAG_H] = low[4];
	// INC and DEC leave C alone
	assign flags_out[`CPU_FLAG_C] = (op == cpu_pkg::alu_inc || op == cpu_pkg::alu_dec) ?
		carry_in : wide[`CPU_DATA_W];

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Kind of the current machine cycle
	typedef enum logic [2:0] {
		mc_fetch,   // Opcode read at PC
		mc_imm_lo,  // First operand byte at PC
		mc_imm_hi,  // Second operand byte, JP only
		mc_mem_rd,  // Read at HL
		mc_mem_wr,  // Write at HL
		mc_jump,    // Internal cycle that loads PC
		mc_halted   // Bus quiet until reset
	} mcycle_t;

	typedef enum logic [1:0] {
		bus_idle,
		bus_read,
		bus_write
	} bus_op_t;

	// First eight follow opcode bits [5:3] of the ALU group
	typedef enum logic [3:0] {
		alu_add, alu_adc, alu_sub, alu_sbc,
		alu_and, alu_xor, alu_or, alu_cp,
		alu_inc, alu_dec,
		alu_pass  // Operand b straight through, for loads
	} alu_op_t;

	// Same order as the 3-bit register fields of the opcodes
	typedef enum logic [2:0] {
		reg_b, reg_c, reg_d, reg_e,
		reg_h, reg_l,
		reg_hl_mem,  // Memory at HL, not a register
		reg_a
	} reg_sel_t;

endpackage

`default_nettype wire

//--- verilog/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Bus widths
`define CPU_ADR_W 16
`define CPU_DATA_W 8

// Every bus access is one machine cycle of this many clocks
`define CPU_MCYCLE_CLOCKS 4

// Address of the first opcode fetch after reset
`define CPU_RESET_PC 16'h0000

// Flag bit positions inside F[7:4]
`define CPU_FLAG_Z 7
`define CPU_FLAG_N 6
`define CPU_FLAG_H 5
`define CPU_FLAG_C 4

`endif
